/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := filt_cfg_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

/* common/filt_cfg_pkg.sv */
// Widths are fixed here for every block and register addresses count 32-bit words
package filt_cfg_pkg;

    localparam int L2_AWIDTH  = 15;
    localparam int TRANS_SIZE = 15;
    localparam int CFG_AWIDTH = 5;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam logic [CFG_AWIDTH-1:0] REG_TX0_BASE  = 5'h00;
    localparam logic [CFG_AWIDTH-1:0] REG_TX1_BASE  = 5'h05;
    localparam logic [CFG_AWIDTH-1:0] REG_RX_BASE   = 5'h0A;
    localparam logic [CFG_AWIDTH-1:0] REG_AU_CFG    = 5'h0F; // Also ends the rx block
    localparam logic [CFG_AWIDTH-1:0] REG_AU_REG0   = 5'h10;
    localparam logic [CFG_AWIDTH-1:0] REG_AU_REG1   = 5'h11;
    localparam logic [CFG_AWIDTH-1:0] REG_FILT_MODE = 5'h16;
    localparam logic [CFG_AWIDTH-1:0] REG_FILT_CMD  = 5'h17;
    localparam logic [CFG_AWIDTH-1:0] REG_STATUS    = 5'h18;

    // Offsets inside a channel block
    localparam logic [2:0] CH_OFS_ADDR = 3'd0;
    localparam logic [2:0] CH_OFS_CFG  = 3'd1;
    localparam logic [2:0] CH_OFS_LEN0 = 3'd2;
    localparam logic [2:0] CH_OFS_LEN1 = 3'd3;
    localparam logic [2:0] CH_OFS_LEN2 = 3'd4;

    // Channel select codes
    localparam logic [1:0] CH_TX0  = 2'd0;
    localparam logic [1:0] CH_TX1  = 2'd1;
    localparam logic [1:0] CH_RX   = 2'd2;
    localparam logic [1:0] CH_NONE = 2'd3;

    //////////////////////////////
    // Field positions
    //////////////////////////////
    localparam int DSIZE_W         = 2;
    localparam int CH_MODE_W       = 2;
    localparam int CH_DSIZE_LSB    = 0;
    localparam int CH_MODE_LSB     = 8;
    localparam int AU_SIGNED_BIT   = 0;
    localparam int AU_BYPASS_BIT   = 1;
    localparam int AU_MODE_W       = 4;
    localparam int AU_MODE_LSB     = 8;
    localparam int AU_SHIFT_W      = 5;
    localparam int AU_SHIFT_LSB    = 16;
    localparam int FILT_MODE_W     = 4;
    localparam int FILT_MODE_LSB   = 0;
    localparam int CMD_START_BIT   = 0;
    localparam int STATUS_DONE_BIT = 0;

    typedef struct packed {
        logic [L2_AWIDTH-1:0]  start_addr;
        logic [DSIZE_W-1:0]    datasize;
        logic [CH_MODE_W-1:0]  mode;
        logic [TRANS_SIZE-1:0] len0;
        logic [TRANS_SIZE-1:0] len1;
        logic [TRANS_SIZE-1:0] len2;
    } chan_cfg_t;

    typedef struct packed {
        logic                   use_signed;
        logic                   bypass;
        logic [AU_MODE_W-1:0]   mode;
        logic [AU_SHIFT_W-1:0]  shift;
        logic [31:0]            reg0;
        logic [31:0]            reg1;
    } au_cfg_t;

    typedef struct packed {
        chan_cfg_t [1:0]        tx;
        chan_cfg_t              rx;
        au_cfg_t                au;
        logic [FILT_MODE_W-1:0] filter_mode;
    } filt_cfg_t;

    typedef struct packed {
        logic                  valid;
        logic                  rwn;    // 1 read, 0 write
        logic [CFG_AWIDTH-1:0] addr;
        logic [31:0]           wdata;
    } cfg_req_t;

    // Which channel block an address falls in
    function automatic logic [1:0] chan_idx(input logic [CFG_AWIDTH-1:0] addr);
        if (addr < REG_TX1_BASE)
            return CH_TX0;
        else if (addr < REG_RX_BASE)
            return CH_TX1;
        else if (addr < REG_AU_CFG)
            return CH_RX;
        return CH_NONE;
    endfunction

    function automatic logic [2:0] chan_ofs(input logic [CFG_AWIDTH-1:0] addr);
        logic [CFG_AWIDTH-1:0] base;
        if (addr < REG_TX1_BASE)
            base = REG_TX0_BASE;
        else if (addr < REG_RX_BASE)
            base = REG_TX1_BASE;
        else
            base = REG_RX_BASE;
        return 3'(addr - base);
    endfunction

endpackage

/* flist.f */
common/filt_cfg_pkg.sv
logic/filt_cfg_stage.sv
logic/filt_commit_ctrl.sv
logic/filt_cfg_readback.sv
logic/filt_cfg_top.sv
verif/filt_cfg_tb.sv

/* logic/filt_cfg_readback.sv */
// Reads answer in the same cycle and the output is zero without an active read
`timescale 1ns/100ps

module filt_cfg_readback (
    input  filt_cfg_pkg::cfg_req_t  cfg_req_i,
    input  filt_cfg_pkg::filt_cfg_t committed_cfg_i,
    input  logic                    done_flag_i,
    output logic [31:0]             cfg_data_o
);

    logic       rd_en;
    logic [2:0] ch_ofs;

    function automatic logic [31:0] chan_rd(
        input filt_cfg_pkg::chan_cfg_t ch,
        input logic [2:0]              ofs
    );
        logic [31:0] word;
        word = '0;
        case (ofs)
            filt_cfg_pkg::CH_OFS_ADDR:
                word[filt_cfg_pkg::L2_AWIDTH-1:0] = ch.start_addr;
            filt_cfg_pkg::CH_OFS_CFG:
            begin
                word[filt_cfg_pkg::CH_DSIZE_LSB +: filt_cfg_pkg::DSIZE_W] = ch.datasize;
                word[filt_cfg_pkg::CH_MODE_LSB +: filt_cfg_pkg::CH_MODE_W] = ch.mode;
            end
            filt_cfg_pkg::CH_OFS_LEN0:
                word[filt_cfg_pkg::TRANS_SIZE-1:0] = ch.len0;
            filt_cfg_pkg::CH_OFS_LEN1:
                word[filt_cfg_pkg::TRANS_SIZE-1:0] = ch.len1;
            filt_cfg_pkg::CH_OFS_LEN2:
                word[filt_cfg_pkg::TRANS_SIZE-1:0] = ch.len2;
            default:
                word = '0;
        endcase
        return word;
    endfunction

    assign rd_en  = cfg_req_i.valid & cfg_req_i.rwn;
    assign ch_ofs = filt_cfg_pkg::chan_ofs(cfg_req_i.addr);

    always_comb
    begin
        cfg_data_o = '0;
        if (rd_en)
        begin
            case (filt_cfg_pkg::chan_idx(cfg_req_i.addr))
                filt_cfg_pkg::CH_TX0:
                    cfg_data_o = chan_rd(committed_cfg_i.tx[0], ch_ofs);
                filt_cfg_pkg::CH_TX1:
                    cfg_data_o = chan_rd(committed_cfg_i.tx[1], ch_ofs);
                filt_cfg_pkg::CH_RX:
                    cfg_data_o = chan_rd(committed_cfg_i.rx, ch_ofs);
                default:
                begin
                    case (cfg_req_i.addr)
                        filt_cfg_pkg::REG_AU_CFG:
                        begin
                            cfg_data_o[filt_cfg_pkg::AU_SIGNED_BIT] =
                                committed_cfg_i.au.use_signed;
                            cfg_data_o[filt_cfg_pkg::AU_BYPASS_BIT] =
                                committed_cfg_i.au.bypass;
                            cfg_data_o[filt_cfg_pkg::AU_MODE_LSB +: filt_cfg_pkg::AU_MODE_W] =
                                committed_cfg_i.au.mode;
                            cfg_data_o[filt_cfg_pkg::AU_SHIFT_LSB +: filt_cfg_pkg::AU_SHIFT_W] =
                                committed_cfg_i.au.shift;
                        end
                        filt_cfg_pkg::REG_AU_REG0:
                            cfg_data_o = committed_cfg_i.au.reg0;
                        filt_cfg_pkg::REG_AU_REG1:
                            cfg_data_o = committed_cfg_i.au.reg1;
                        filt_cfg_pkg::REG_FILT_MODE:
                            cfg_data_o[filt_cfg_pkg::FILT_MODE_LSB +: filt_cfg_pkg::FILT_MODE_W] =
                                committed_cfg_i.filter_mode;
                        filt_cfg_pkg::REG_STATUS:
                            cfg_data_o[filt_cfg_pkg::STATUS_DONE_BIT] = done_flag_i;
                        default:
                            cfg_data_o = '0; // Cmd and unmapped words
                    endcase
                end
            endcase
        end
    end

endmodule

/* logic/filt_cfg_stage.sv */
// Command writes must come at least two bus cycles apart and 0x12 to 0x15 ignore writes
`timescale 1ns/100ps

module filt_cfg_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  filt_cfg_pkg::cfg_req_t cfg_req_i,
    input  logic                   filter_done_i,
    output filt_cfg_pkg::filt_cfg_t staged_cfg_o,
    output logic                   start_req_o,
    output logic                   done_flag_o
);

    filt_cfg_pkg::filt_cfg_t staged_q;
    filt_cfg_pkg::filt_cfg_t staged_d;
    logic                    wr_en;
    logic [2:0]              ch_ofs;
    logic                    cmd_start;
    logic                    status_clr;
    logic                    start_req_q;
    logic                    done_q;

    // One register of a channel block
    function automatic filt_cfg_pkg::chan_cfg_t chan_wr(
        input filt_cfg_pkg::chan_cfg_t cur,
        input logic [2:0]              ofs,
        input logic [31:0]             data
    );
        filt_cfg_pkg::chan_cfg_t nxt;
        nxt = cur;
        case (ofs)
            filt_cfg_pkg::CH_OFS_ADDR:
                nxt.start_addr = data[filt_cfg_pkg::L2_AWIDTH-1:0];
            filt_cfg_pkg::CH_OFS_CFG:
            begin
                nxt.datasize = data[filt_cfg_pkg::CH_DSIZE_LSB +: filt_cfg_pkg::DSIZE_W];
                nxt.mode     = data[filt_cfg_pkg::CH_MODE_LSB +: filt_cfg_pkg::CH_MODE_W];
            end
            filt_cfg_pkg::CH_OFS_LEN0:
                nxt.len0 = data[filt_cfg_pkg::TRANS_SIZE-1:0];
            filt_cfg_pkg::CH_OFS_LEN1:
                nxt.len1 = data[filt_cfg_pkg::TRANS_SIZE-1:0];
            filt_cfg_pkg::CH_OFS_LEN2:
                nxt.len2 = data[filt_cfg_pkg::TRANS_SIZE-1:0];
            default:
                nxt = cur;
        endcase
        return nxt;
    endfunction

    assign wr_en  = cfg_req_i.valid & ~cfg_req_i.rwn;
    assign ch_ofs = filt_cfg_pkg::chan_ofs(cfg_req_i.addr);

    assign cmd_start  = wr_en && (cfg_req_i.addr == filt_cfg_pkg::REG_FILT_CMD)
                        && cfg_req_i.wdata[filt_cfg_pkg::CMD_START_BIT];
    assign status_clr = wr_en && (cfg_req_i.addr == filt_cfg_pkg::REG_STATUS)
                        && cfg_req_i.wdata[filt_cfg_pkg::STATUS_DONE_BIT];

    //////////////////////////////
    // Write decode
    //////////////////////////////
    always_comb
    begin
        staged_d = staged_q;
        if (wr_en)
        begin
            case (filt_cfg_pkg::chan_idx(cfg_req_i.addr))
                filt_cfg_pkg::CH_TX0:
                    staged_d.tx[0] = chan_wr(staged_q.tx[0], ch_ofs, cfg_req_i.wdata);
                filt_cfg_pkg::CH_TX1:
                    staged_d.tx[1] = chan_wr(staged_q.tx[1], ch_ofs, cfg_req_i.wdata);
                filt_cfg_pkg::CH_RX:
                    staged_d.rx = chan_wr(staged_q.rx, ch_ofs, cfg_req_i.wdata);
                default:
                begin
                    case (cfg_req_i.addr)
                        filt_cfg_pkg::REG_AU_CFG:
                        begin
                            staged_d.au.use_signed =
                                cfg_req_i.wdata[filt_cfg_pkg::AU_SIGNED_BIT];
                            staged_d.au.bypass =
                                cfg_req_i.wdata[filt_cfg_pkg::AU_BYPASS_BIT];
                            staged_d.au.mode =
                                cfg_req_i.wdata[filt_cfg_pkg::AU_MODE_LSB +: filt_cfg_pkg::AU_MODE_W];
                            staged_d.au.shift =
                                cfg_req_i.wdata[filt_cfg_pkg::AU_SHIFT_LSB +: filt_cfg_pkg::AU_SHIFT_W];
                        end
                        filt_cfg_pkg::REG_AU_REG0:
                            staged_d.au.reg0 = cfg_req_i.wdata;
                        filt_cfg_pkg::REG_AU_REG1:
                            staged_d.au.reg1 = cfg_req_i.wdata;
                        filt_cfg_pkg::REG_FILT_MODE:
                            staged_d.filter_mode = cfg_req_i.wdata[
                                filt_cfg_pkg::FILT_MODE_LSB +: filt_cfg_pkg::FILT_MODE_W];
                        default:
                            staged_d = staged_q; // Cmd, status and holes
                    endcase
                end
            endcase
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            staged_q    <= '0;
            start_req_q <= 1'b0;
            done_q      <= 1'b0;
        end
        else
        begin
            staged_q    <= staged_d;
            start_req_q <= cmd_start;
            if (status_clr)
                done_q <= 1'b0;         // Clear beats a same-edge done
            else if (filter_done_i)
                done_q <= 1'b1;
        end
    end

    assign staged_cfg_o = staged_q;
    assign start_req_o  = start_req_q;
    assign done_flag_o  = done_q;

    a_start_req_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        start_req_o |=> !start_req_o)
        else $error("start request held for two cycles");

endmodule

/* logic/filt_cfg_top.sv */
// Register accesses complete in their own cycle and there is no back-pressure
`timescale 1ns/100ps

module filt_cfg_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  filt_cfg_pkg::cfg_req_t  cfg_req_i,
    input  logic                    filter_done_i,
    output logic [31:0]             cfg_data_o,
    output filt_cfg_pkg::filt_cfg_t cfg_o,
    output logic                    start_o
);

    filt_cfg_pkg::filt_cfg_t staged_cfg;
    filt_cfg_pkg::filt_cfg_t committed_cfg;
    logic                    start_req;
    logic                    done_flag;

    //////////////////////////////
    // Staging registers
    //////////////////////////////
    filt_cfg_stage u_stage (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cfg_req_i     (cfg_req_i),
        .filter_done_i (filter_done_i),
        .staged_cfg_o  (staged_cfg),
        .start_req_o   (start_req),
        .done_flag_o   (done_flag)
    );

    //////////////////////////////
    // Commit and launch
    //////////////////////////////
    filt_commit_ctrl u_commit (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .staged_cfg_i    (staged_cfg),
        .start_req_i     (start_req),
        .filter_done_i   (filter_done_i),
        .committed_cfg_o (committed_cfg),
        .start_o         (start_o)
    );

    filt_cfg_readback u_readback (
        .cfg_req_i       (cfg_req_i),
        .committed_cfg_i (committed_cfg),
        .done_flag_i     (done_flag),
        .cfg_data_o      (cfg_data_o)
    );

    assign cfg_o = committed_cfg; // Filter sees only the committed set

endmodule

/* logic/filt_commit_ctrl.sv */
// Holds at most one pending run request and launches it on the next filter done pulse
`timescale 1ns/100ps

module filt_commit_ctrl (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  filt_cfg_pkg::filt_cfg_t staged_cfg_i,
    input  logic                    start_req_i,
    input  logic                    filter_done_i,
    output filt_cfg_pkg::filt_cfg_t committed_cfg_o,
    output logic                    start_o
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SAMPLE = 2'd1;
    localparam logic [1:0] ST_BUSY   = 2'd2;

    logic [1:0]              state_q;
    logic [1:0]              state_d;
    logic                    pending_q;
    logic                    pending_d;
    logic                    commit;
    filt_cfg_pkg::filt_cfg_t committed_q;

    //////////////////////////////
    // Run control
    //////////////////////////////
    always_comb
    begin
        state_d   = state_q;
        pending_d = pending_q;
        commit    = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                if (start_req_i)
                begin
                    commit  = 1'b1;
                    state_d = ST_SAMPLE;
                end
            end
            ST_SAMPLE:
            begin
                state_d = ST_BUSY;
                if (start_req_i)
                    pending_d = 1'b1; // Queued behind the run just launched
            end
            ST_BUSY:
            begin
                if (filter_done_i && (start_req_i || pending_q))
                begin
                    commit    = 1'b1;
                    pending_d = 1'b0;
                    state_d   = ST_SAMPLE;
                end
                else if (filter_done_i)
                begin
                    state_d = ST_IDLE;
                end
                else if (start_req_i)
                begin
                    pending_d = 1'b1;
                end
            end
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q     <= ST_IDLE;
            pending_q   <= 1'b0;
            committed_q <= '0;
        end
        else
        begin
            state_q   <= state_d;
            pending_q <= pending_d;
            if (commit)
                committed_q <= staged_cfg_i;
        end
    end

    assign start_o         = (state_q == ST_SAMPLE);
    assign committed_cfg_o = committed_q;

    // Idle never holds a queued run
    a_idle_no_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == ST_IDLE) |-> !pending_q)
        else $error("pending request left behind in idle");

    // Running filter must never see its setup move
    a_commit_only: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $changed(committed_q) |-> start_o)
        else $error("committed set changed outside a commit");

endmodule

/* verif/filt_cfg_tb.sv */
// Table entries run one per clock and every start_o pulse is expected on an idle entry
`timescale 1ns/100ps

module filt_cfg_tb;

    localparam int CLK_PERIOD = 8;

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_DONE = 2'd2;
    localparam logic [1:0] OP_IDLE = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        rnd;       // Fresh random write data
        logic        use_model; // Expected read comes from the model
        logic [31:0] exp_rd;
        logic        exp_start;
    } entry_t;

    logic                    clk_i;
    logic                    rstn_i;
    filt_cfg_pkg::cfg_req_t  cfg_req;
    logic                    filter_done;
    logic [31:0]             cfg_data;
    filt_cfg_pkg::filt_cfg_t cfg_out;
    logic                    start;

    entry_t      tbl[$];
    int          tbl_len = 0;
    logic [31:0] stg [0:31];  // Staged words, masked
    logic [31:0] com [0:31];  // Committed words as the bus reads them
    logic [31:0] snap [0:31];
    logic        done_m;
    logic        busy_m;
    logic        pending_m;
    int          delay_m;

    filt_cfg_top uut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cfg_req_i     (cfg_req),
        .filter_done_i (filter_done),
        .cfg_data_o    (cfg_data),
        .cfg_o         (cfg_out),
        .start_o       (start)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [287:0] got,
                               input logic [287:0] exp);
        if (got !== exp)
        begin
            $display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    //////////////////////////////
    // Table builders
    //////////////////////////////
    task automatic add_entry(input logic [1:0] op, input logic [4:0] addr,
                             input logic [31:0] data, input logic rnd, input logic use_model,
                             input logic [31:0] exp_rd, input logic exp_start);
        entry_t e;
        e.op        = op;
        e.addr      = addr;
        e.data      = data;
        e.rnd       = rnd;
        e.use_model = use_model;
        e.exp_rd    = exp_rd;
        e.exp_start = exp_start;
        tbl.push_back(e);
    endtask

    task automatic add_write(input logic [4:0] addr, input logic [31:0] data);
        add_entry(OP_WR, addr, data, 1'b0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic add_rand_write(input logic [4:0] addr);
        add_entry(OP_WR, addr, 32'h0, 1'b1, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic add_read(input logic [4:0] addr);
        add_entry(OP_RD, addr, 32'h0, 1'b0, 1'b1, 32'h0, 1'b0);
    endtask

    task automatic add_read_const(input logic [4:0] addr, input logic [31:0] exp);
        add_entry(OP_RD, addr, 32'h0, 1'b0, 1'b0, exp, 1'b0);
    endtask

    task automatic add_done();
        add_entry(OP_DONE, 5'h0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic add_idle(input logic exp_start);
        add_entry(OP_IDLE, 5'h0, 32'h0, 1'b0, 1'b0, 32'h0, exp_start);
    endtask

    task automatic add_read_all();
        for (int a = 0; a <= 24; a++)
            add_read(5'(a));
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] field_mask(input logic [4:0] addr);
        int a;
        a = int'(addr);
        if (a <= 14)
            return ((a % 5) == 1) ? 32'h0000_0303 : 32'h0000_7FFF;
        case (a)
            15:      return 32'h001F_0F03;  // signed, bypass, mode, shift
            16, 17:  return 32'hFFFF_FFFF;
            22:      return 32'h0000_000F;
            default: return 32'h0;
        endcase
    endfunction

    function automatic filt_cfg_pkg::chan_cfg_t chan_expect(input int base);
        filt_cfg_pkg::chan_cfg_t c;
        c.start_addr = com[base][14:0];
        c.datasize   = com[base+1][1:0];
        c.mode       = com[base+1][9:8];
        c.len0       = com[base+2][14:0];
        c.len1       = com[base+3][14:0];
        c.len2       = com[base+4][14:0];
        return c;
    endfunction

    function automatic filt_cfg_pkg::filt_cfg_t cfg_expect();
        filt_cfg_pkg::filt_cfg_t c;
        c.tx[0]         = chan_expect(0);
        c.tx[1]         = chan_expect(5);
        c.rx            = chan_expect(10);
        c.au.use_signed = com[15][0];
        c.au.bypass     = com[15][1];
        c.au.mode       = com[15][11:8];
        c.au.shift      = com[15][20:16];
        c.au.reg0       = com[16];
        c.au.reg1       = com[17];
        c.filter_mode   = com[22][3:0];
        return c;
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] addr);
        if (addr == 5'h18)
            return {31'b0, done_m};
        return com[addr];
    endfunction

    task automatic model_update(input entry_t e, input logic [31:0] wdata);
        case (e.op)
            OP_WR:
            begin
                if (e.addr == 5'h17)
                begin
                    if (wdata[0] && !busy_m)
                    begin
                        snap    = stg;
                        delay_m = 2;   // Visible two entries later
                        busy_m  = 1'b1;
                    end
                    else if (wdata[0])
                        pending_m = 1'b1;
                end
                else if (e.addr == 5'h18)
                begin
                    if (wdata[0])
                        done_m = 1'b0;
                end
                else
                    stg[e.addr] = wdata & field_mask(e.addr);
            end
            OP_DONE:
            begin
                done_m = 1'b1;
                if (busy_m && pending_m)
                begin
                    snap      = stg;
                    delay_m   = 1;
                    pending_m = 1'b0;
                end
                else if (busy_m)
                    busy_m = 1'b0;
            end
            default:
                ;
        endcase
    endtask

    initial
    begin
        wait (tbl_len > 0);
        #((tbl_len * 20 + 10) * CLK_PERIOD);
        $display("Run timed out before the stimulus table finished");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        entry_t      e;
        logic [31:0] wdata;
        logic [31:0] exp;
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        cfg_req     = '0;
        filter_done = 1'b0;
        done_m      = 1'b0;
        busy_m      = 1'b0;
        pending_m   = 1'b0;
        delay_m     = 0;
        void'($urandom(32'h346a));
        for (int a = 0; a < 32; a++)
        begin
            stg[a]  = 32'h0;
            com[a]  = 32'h0;
            snap[a] = 32'h0;
        end

        add_read_all();                  // Reset values
        add_idle(1'b0);
        for (int a = 0; a <= 22; a++)
            add_rand_write(5'(a));
        add_read_all();                  // Nothing committed yet
        add_write(5'h17, 32'h1);
        add_idle(1'b0);
        add_idle(1'b1);
        add_idle(1'b0);
        add_read_all();

        //////////////////////////////
        // Command while busy
        //////////////////////////////
        for (int a = 0; a <= 4; a++)
            add_rand_write(5'(a));
        add_write(5'h17, 32'h1);
        add_idle(1'b0);
        add_idle(1'b0);
        add_idle(1'b0);
        for (int a = 0; a <= 4; a++)
            add_read(5'(a));
        add_rand_write(5'h10);
        add_done();
        add_idle(1'b1);                  // Pending run launches
        add_idle(1'b0);
        for (int a = 0; a <= 4; a++)
            add_read(5'(a));
        add_read(5'h10);
        add_done();                      // Nothing pending, back to idle
        add_idle(1'b0);
        add_idle(1'b0);
        add_write(5'h17, 32'h1);
        add_idle(1'b0);
        add_idle(1'b1);
        add_idle(1'b0);
        add_done();
        add_idle(1'b0);

        // Sticky done flag
        add_write(5'h18, 32'h1);
        add_read_const(5'h18, 32'h0);
        add_done();
        add_read_const(5'h18, 32'h1);
        add_idle(1'b0);
        add_read_const(5'h18, 32'h1);
        add_write(5'h18, 32'h0);
        add_read_const(5'h18, 32'h1);
        add_write(5'h18, 32'h1);
        add_read_const(5'h18, 32'h0);

        // Holes and command word
        for (int a = 18; a <= 21; a++)
            add_write(5'(a), 32'hFFFF_FFFF);
        add_write(5'h17, 32'hFFFF_FFFE);
        add_idle(1'b0);
        add_idle(1'b0);
        add_idle(1'b0);
        for (int a = 18; a <= 21; a++)
            add_read_const(5'(a), 32'h0);
        add_read_const(5'h17, 32'h0);
        add_write(5'h17, 32'h1);
        add_idle(1'b0);
        add_idle(1'b1);
        add_idle(1'b0);
        add_read_all();
        tbl_len = tbl.size();

        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;

        foreach (tbl[i])
        begin
            e = tbl[i];
            @(negedge clk_i);
            if (delay_m > 0)
            begin
                delay_m--;
                if (delay_m == 0)
                    com = snap;
            end
            wdata             = e.rnd ? $urandom() : e.data;
            cfg_req.valid     = (e.op == OP_WR) || (e.op == OP_RD);
            cfg_req.rwn       = (e.op == OP_RD);
            cfg_req.addr      = e.addr;
            cfg_req.wdata     = wdata;
            filter_done       = (e.op == OP_DONE);
            #1;
            if (e.op == OP_RD)
                exp = e.use_model ? model_read(e.addr) : e.exp_rd;
            else
                exp = 32'h0;     // Idle bus reads zero
            check_value("start_o", 288'(start), 288'(e.exp_start));
            check_value("cfg_data_o", 288'(cfg_data), 288'(exp));
            check_value("cfg_o", 288'(cfg_out), 288'(cfg_expect()));
            model_update(e, wdata);
        end

        @(negedge clk_i);
        cfg_req     = '0;
        filter_done = 1'b0;
        $display(">>> PASS");
        $finish;
    end

endmodule
